//--- src/cpld_pkg.sv
// Shared constants; SPI mode 0 with one byte per transfer, LSB first, and the widths are fixed.
package cpld_pkg;

  // Width of an SPI byte and of the command and status registers.
  localparam int byte_w = 8;

  // Width of the bit index inside one byte.
  localparam int bit_idx_w = 3;

  // Flops in each SPI input synchronizer, at least two.
  localparam int sync_depth = 2;

  // Width of the coprocessor device select bus.
  localparam int dev_w = 3;

  // Width of the port phase code.
  localparam int phase_w = 2;

  // Opcodes accepted on the MCU bus.
  localparam logic [byte_w-1:0] mcu_op_read_status = 8'd1;
  localparam logic [byte_w-1:0] mcu_op_write_command = 8'd2;
  localparam logic [byte_w-1:0] mcu_op_access_ram = 8'd3;
  localparam logic [byte_w-1:0] mcu_op_reset_cop = 8'd4;

  // Opcodes accepted on the coprocessor bus.
  localparam logic [byte_w-1:0] cop_op_read_command = 8'd1;
  localparam logic [byte_w-1:0] cop_op_write_status = 8'd2;
  localparam logic [byte_w-1:0] cop_op_access_ram = 8'd3;

  // Device codes carried on cop_nss.
  // Zero selects nothing.
  localparam logic [dev_w-1:0] dev_none = 3'd0;
  // This logic, reached through its own SPI slave port.
  localparam logic [dev_w-1:0] dev_logic = 3'd1;
  localparam logic [dev_w-1:0] dev_sdcard = 3'd2;
  localparam logic [dev_w-1:0] dev_usb = 3'd3;
  localparam logic [dev_w-1:0] dev_fpga = 3'd4;
  // Configuration flash, shared with the FPGA.
  localparam logic [dev_w-1:0] dev_flash = 3'd5;

  // Port phases.
  // The first byte of a frame is the opcode.
  localparam logic [phase_w-1:0] phase_opcode = 2'd0;
  // Every later byte belongs to the body.
  localparam logic [phase_w-1:0] phase_body = 2'd1;

endpackage

//--- src/spi_byte_engine.sv
// SPI mode 0 slave, LSB first; SCK half period must span at least four cop_sck cycles.
`timescale 1ns/1ps

module spi_byte_engine import cpld_pkg::*; (
  input  logic                 cop_sck,
  input  logic                 cop_rst_n,
  input  logic                 nss,
  input  logic                 sck,
  input  logic                 mosi,
  output logic [byte_w-1:0]    rx_byte,
  output logic [bit_idx_w-1:0] bit_idx,
  output logic                 byte_strobe,
  output logic                 frame_start,
  output logic                 sel
);

  // Synchronizer chains for the three SPI inputs.
  logic [sync_depth-1:0] nss_sync;
  logic [sync_depth-1:0] sck_sync;
  logic [sync_depth-1:0] mosi_sync;

  // Delayed copies for edge detection.
  logic sck_q;
  logic sel_q;

  // Receive shifter.
  logic [byte_w-1:0] shifter;

  logic sck_rise;
  logic sck_fall;

  // Inputs are asynchronous to cop_sck.
  // Idle values are deselected and clock low.
  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      nss_sync <= '1;
      sck_sync <= '0;
      mosi_sync <= '0;
    end else begin
      nss_sync <= {nss_sync[sync_depth-2:0], nss};
      sck_sync <= {sck_sync[sync_depth-2:0], sck};
      mosi_sync <= {mosi_sync[sync_depth-2:0], mosi};
    end
  end

  // Select is active low on the pin.
  assign sel = ~nss_sync[sync_depth-1];

  // Edges of the synchronized SPI clock.
  assign sck_rise = sck_sync[sync_depth-1] & ~sck_q;
  assign sck_fall = ~sck_sync[sync_depth-1] & sck_q;

  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      sck_q <= 1'b0;
      sel_q <= 1'b0;
      frame_start <= 1'b0;
      byte_strobe <= 1'b0;
      bit_idx <= '0;
      shifter <= '0;
    end else begin
      sck_q <= sck_sync[sync_depth-1];
      sel_q <= sel;
      // One pulse as the select goes inactive, so the next frame opens clean.
      frame_start <= sel_q & ~sel;
      // The eighth rising edge is seen while the index still reads seven.
      byte_strobe <= sel & sck_rise & (bit_idx == '1);
      if (!sel) begin
        bit_idx <= '0;
        shifter <= '0;
      end else begin
        // Sample on the rising edge.
        // New bits enter at the top, so the first bit ends at bit zero.
        if (sck_rise) begin
          shifter <= {mosi_sync[sync_depth-1], shifter[byte_w-1:1]};
        end
        // Advance on the falling edge.
        // The index wraps to zero after the eighth bit.
        if (sck_fall) begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
    end
  end

  // The strobe lags the last shift by one cycle, so the byte is complete here.
  assign rx_byte = shifter;

endmodule

//--- src/mcu_port_ctrl.sv
// MCU command port; the strobe has no back-pressure and an unknown opcode makes the frame inert.
`timescale 1ns/1ps

module mcu_port_ctrl import cpld_pkg::*; (
  input  logic               cop_sck,
  input  logic               cop_rst_n,
  input  logic [byte_w-1:0]  rx_byte,
  input  logic               byte_strobe,
  input  logic               frame_start,
  input  logic               sel,
  output logic [byte_w-1:0]  command,
  output logic [phase_w-1:0] phase,
  output logic [byte_w-1:0]  opcode,
  output logic               ram_req,
  output logic               cop_nreset
);

  logic opcode_byte;
  logic body_byte;

  // Byte classification for the current strobe.
  assign opcode_byte = byte_strobe & (phase == phase_opcode);
  assign body_byte = byte_strobe & (phase == phase_body);

  // Opcode machine.
  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      phase <= phase_opcode;
      opcode <= '0;
      ram_req <= 1'b0;
    end else if (frame_start) begin
      // Frame over.
      // Zero is no opcode, so nothing stays active between frames.
      phase <= phase_opcode;
      opcode <= '0;
      ram_req <= 1'b0;
    end else if (opcode_byte) begin
      phase <= phase_body;
      opcode <= rx_byte;
      // RAM request stays up for the rest of the frame.
      ram_req <= (rx_byte == mcu_op_access_ram);
    end
  end

  // Command register.
  // Every body byte of a write frame overwrites it, so the last one wins.
  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      command <= '0;
    end else if (body_byte && (opcode == mcu_op_write_command)) begin
      command <= rx_byte;
    end
  end

  // Coprocessor reset request.
  // Falls right after the opcode byte and rises once the MCU deselects.
  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      cop_nreset <= 1'b1;
    end else if (!sel) begin
      cop_nreset <= 1'b1;
    end else if (opcode_byte && (rx_byte == mcu_op_reset_cop)) begin
      cop_nreset <= 1'b0;
    end
  end

endmodule

//--- src/cop_port_ctrl.sv
// Coprocessor port; select decode is combinational from cop_nss and unused codes select nothing.
`timescale 1ns/1ps

module cop_port_ctrl import cpld_pkg::*; (
  input  logic              cop_sck,
  input  logic              cop_rst_n,
  input  logic [byte_w-1:0] rx_byte,
  input  logic              byte_strobe,
  input  logic              frame_start,
  input  logic [dev_w-1:0]  cop_nss,
  input  logic              cop_sck_pin,
  input  logic              cop_mosi,
  output logic [byte_w-1:0] status,
  output logic [byte_w-1:0] opcode,
  output logic              ram_req,
  output logic              usb_nss,
  output logic              sdc_nss,
  output logic              fpga_nss,
  output logic              flash_nss,
  output logic              flash_sck,
  output logic              flash_mosi,
  output logic              fpga_nce,
  output logic              fpga_nconfig,
  output logic              logic_nss
);

  logic [phase_w-1:0] phase;
  logic               flash_sel;
  logic               opcode_byte;
  logic               body_byte;

  // Peripheral selects, all active low.
  // At most one can be low for any code.
  assign logic_nss = (cop_nss != dev_logic);
  assign usb_nss = (cop_nss != dev_usb);
  assign sdc_nss = (cop_nss != dev_sdcard);
  assign fpga_nss = (cop_nss != dev_fpga);

  // Flash bus.
  assign flash_sel = (cop_nss == dev_flash);
  assign flash_nss = ~flash_sel;
  // Clock and data sit low while the flash is idle.
  assign flash_sck = flash_sel & cop_sck_pin;
  assign flash_mosi = flash_sel & cop_mosi;

  // The FPGA lets go of the flash bus while nCE is high and nCONFIG low.
  assign fpga_nce = flash_sel;
  assign fpga_nconfig = ~flash_sel;

  assign opcode_byte = byte_strobe & (phase == phase_opcode);
  assign body_byte = byte_strobe & (phase == phase_body);

  // Opcode machine.
  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      phase <= phase_opcode;
      opcode <= '0;
      ram_req <= 1'b0;
    end else if (frame_start) begin
      // Deselect of the logic port ends the frame.
      phase <= phase_opcode;
      opcode <= '0;
      ram_req <= 1'b0;
    end else if (opcode_byte) begin
      phase <= phase_body;
      opcode <= rx_byte;
      ram_req <= (rx_byte == cop_op_access_ram);
    end
  end

  // Status register.
  // The MCU reads it back through its own port.
  always_ff @(posedge cop_sck or negedge cop_rst_n) begin
    if (!cop_rst_n) begin
      status <= '0;
    end else if (body_byte && (opcode == cop_op_write_status)) begin
      status <= rx_byte;
    end
  end

endmodule

//--- src/ram_bus_arbiter.sv
// RAM bus mux and MISO routing; purely combinational, ownership follows the command register.
`timescale 1ns/1ps

module ram_bus_arbiter import cpld_pkg::*; (
  input  logic                 cop_sck,
  input  logic [byte_w-1:0]    command,
  input  logic [byte_w-1:0]    status,
  input  logic [byte_w-1:0]    mcu_opcode,
  input  logic [byte_w-1:0]    cop_opcode,
  input  logic                 mcu_ram_req,
  input  logic                 cop_ram_req,
  input  logic [bit_idx_w-1:0] mcu_bit_idx,
  input  logic [bit_idx_w-1:0] cop_bit_idx,
  input  logic                 mcu_rx_lsb,
  input  logic                 cop_rx_lsb,
  input  logic                 mcu_nss,
  input  logic                 mcu_sck,
  input  logic                 mcu_mosi,
  input  logic                 logic_nss,
  input  logic                 cop_sck_pin,
  input  logic                 cop_mosi,
  input  logic [dev_w-1:0]     cop_nss,
  input  logic                 ram_miso,
  input  logic                 sys_miso,
  input  logic                 flash_miso,
  output logic                 ram_nss,
  output logic                 ram_sck,
  output logic                 ram_mosi,
  output logic                 mcu_miso,
  output logic                 cop_miso
);

  logic mcu_owner;
  logic mcu_ram_en;
  logic cop_ram_en;

  // A zero command leaves the RAM with the MCU.
  // Any other value hands it to the coprocessor.
  assign mcu_owner = (command == '0);

  // Only the owner's request opens the RAM bus.
  assign mcu_ram_en = mcu_owner & mcu_ram_req;
  assign cop_ram_en = ~mcu_owner & cop_ram_req;

  // RAM pins.
  always_comb begin
    ram_nss = 1'b1;
    ram_sck = 1'b0;
    ram_mosi = 1'b0;
    if (mcu_ram_en) begin
      ram_nss = mcu_nss;
      ram_sck = mcu_sck;
      ram_mosi = mcu_mosi;
    end else if (cop_ram_en) begin
      ram_nss = logic_nss;
      ram_sck = cop_sck_pin;
      ram_mosi = cop_mosi;
    end
  end

  // MCU MISO.
  // Without a read or RAM access the received bits echo back.
  always_comb begin
    if (mcu_opcode == mcu_op_read_status) begin
      mcu_miso = status[mcu_bit_idx];
    end else if (mcu_ram_en) begin
      mcu_miso = ram_miso;
    end else begin
      mcu_miso = mcu_rx_lsb;
    end
  end

  // Coprocessor MISO, chosen by the device it addresses.
  always_comb begin
    case (cop_nss)
      dev_logic: begin
        if (cop_opcode == cop_op_read_command) begin
          cop_miso = command[cop_bit_idx];
        end else if (cop_ram_en) begin
          cop_miso = ram_miso;
        end else begin
          cop_miso = cop_rx_lsb;
        end
      end
      dev_sdcard, dev_usb, dev_fpga: cop_miso = sys_miso;
      dev_flash: cop_miso = flash_miso;
      // dev_none and unused codes.
      default: cop_miso = 1'b0;
    endcase
  end

endmodule

//--- src/cpld_glue_top.sv
// Board glue top; both SPI buses are oversampled by cop_sck, so their clocks must be much slower.
`timescale 1ns/1ps

module cpld_glue_top import cpld_pkg::*; (
  input  logic             cop_sck,
  input  logic             cop_rst_n,
  // MCU SPI bus, this logic is the slave.
  input  logic             mcu_nss,
  input  logic             mcu_sck,
  input  logic             mcu_mosi,
  output logic             mcu_miso,
  // Coprocessor SPI bus, with an encoded device select.
  input  logic [dev_w-1:0] cop_nss,
  input  logic             cop_spi_sck,
  input  logic             cop_mosi,
  output logic             cop_miso,
  output logic             cop_nreset,
  // Serial RAM, this logic is the master.
  output logic             ram_nss,
  output logic             ram_sck,
  output logic             ram_mosi,
  input  logic             ram_miso,
  // Peripherals sharing the coprocessor bus.
  output logic             usb_nss,
  output logic             sdc_nss,
  output logic             fpga_nss,
  input  logic             sys_miso,
  // Configuration flash.
  output logic             flash_nss,
  output logic             flash_sck,
  output logic             flash_mosi,
  input  logic             flash_miso,
  output logic             fpga_nce,
  output logic             fpga_nconfig
);

  // MCU engine results.
  logic [byte_w-1:0]    mcu_rx_byte;
  logic [bit_idx_w-1:0] mcu_bit_idx;
  logic                 mcu_byte_strobe;
  logic                 mcu_frame_start;
  logic                 mcu_sel;

  // Coprocessor engine results.
  logic [byte_w-1:0]    cop_rx_byte;
  logic [bit_idx_w-1:0] cop_bit_idx;
  logic                 cop_byte_strobe;
  logic                 cop_frame_start;

  // Controller results.
  logic [byte_w-1:0]    command;
  logic [byte_w-1:0]    status;
  logic [byte_w-1:0]    mcu_opcode;
  logic [byte_w-1:0]    cop_opcode;
  logic                 mcu_ram_req;
  logic                 cop_ram_req;
  logic                 logic_nss;

  spi_byte_engine u_mcu_engine (
    .cop_sck     (cop_sck),
    .cop_rst_n   (cop_rst_n),
    .nss         (mcu_nss),
    .sck         (mcu_sck),
    .mosi        (mcu_mosi),
    .rx_byte     (mcu_rx_byte),
    .bit_idx     (mcu_bit_idx),
    .byte_strobe (mcu_byte_strobe),
    .frame_start (mcu_frame_start),
    .sel         (mcu_sel)
  );

  // The coprocessor port answers only to the dev_logic code.
  spi_byte_engine u_cop_engine (
    .cop_sck     (cop_sck),
    .cop_rst_n   (cop_rst_n),
    .nss         (logic_nss),
    .sck         (cop_spi_sck),
    .mosi        (cop_mosi),
    .rx_byte     (cop_rx_byte),
    .bit_idx     (cop_bit_idx),
    .byte_strobe (cop_byte_strobe),
    .frame_start (cop_frame_start),
    .sel         ()
  );

  mcu_port_ctrl u_mcu_ctrl (
    .cop_sck     (cop_sck),
    .cop_rst_n   (cop_rst_n),
    .rx_byte     (mcu_rx_byte),
    .byte_strobe (mcu_byte_strobe),
    .frame_start (mcu_frame_start),
    .sel         (mcu_sel),
    .command     (command),
    .phase       (),
    .opcode      (mcu_opcode),
    .ram_req     (mcu_ram_req),
    .cop_nreset  (cop_nreset)
  );

  cop_port_ctrl u_cop_ctrl (
    .cop_sck      (cop_sck),
    .cop_rst_n    (cop_rst_n),
    .rx_byte      (cop_rx_byte),
    .byte_strobe  (cop_byte_strobe),
    .frame_start  (cop_frame_start),
    .cop_nss      (cop_nss),
    .cop_sck_pin  (cop_spi_sck),
    .cop_mosi     (cop_mosi),
    .status       (status),
    .opcode       (cop_opcode),
    .ram_req      (cop_ram_req),
    .usb_nss      (usb_nss),
    .sdc_nss      (sdc_nss),
    .fpga_nss     (fpga_nss),
    .flash_nss    (flash_nss),
    .flash_sck    (flash_sck),
    .flash_mosi   (flash_mosi),
    .fpga_nce     (fpga_nce),
    .fpga_nconfig (fpga_nconfig),
    .logic_nss    (logic_nss)
  );

  ram_bus_arbiter u_arbiter (
    .cop_sck     (cop_sck),
    .command     (command),
    .status      (status),
    .mcu_opcode  (mcu_opcode),
    .cop_opcode  (cop_opcode),
    .mcu_ram_req (mcu_ram_req),
    .cop_ram_req (cop_ram_req),
    .mcu_bit_idx (mcu_bit_idx),
    .cop_bit_idx (cop_bit_idx),
    .mcu_rx_lsb  (mcu_rx_byte[0]),
    .cop_rx_lsb  (cop_rx_byte[0]),
    .mcu_nss     (mcu_nss),
    .mcu_sck     (mcu_sck),
    .mcu_mosi    (mcu_mosi),
    .logic_nss   (logic_nss),
    .cop_sck_pin (cop_spi_sck),
    .cop_mosi    (cop_mosi),
    .cop_nss     (cop_nss),
    .ram_miso    (ram_miso),
    .sys_miso    (sys_miso),
    .flash_miso  (flash_miso),
    .ram_nss     (ram_nss),
    .ram_sck     (ram_sck),
    .ram_mosi    (ram_mosi),
    .mcu_miso    (mcu_miso),
    .cop_miso    (cop_miso)
  );

endmodule

//--- tb/cpld_glue_props.sv
// Sampled on rising cop_sck only, so glitches between edges go unseen; holds from reset onward.
`timescale 1ns/1ps

module cpld_glue_props import cpld_pkg::*; (
  input logic              cop_sck,
  input logic [byte_w-1:0] command,
  input logic              mcu_ram_req,
  input logic              cop_ram_req,
  input logic [dev_w-1:0]  cop_nss,
  input logic              ram_nss,
  input logic              ram_sck,
  input logic              ram_mosi
);

  int failures = 0;

  // RAM bus idles while neither port requests it.
  ram_idle_a: assert property (@(posedge cop_sck)
    (!mcu_ram_req && !cop_ram_req) |-> (ram_nss && !ram_sck && !ram_mosi))
    else begin
      failures++;
      $error("RAM bus active with no request");
    end

  // On the coprocessor bus, the RAM select is low only together with the dev_logic code.
  cop_select_a: assert property (@(posedge cop_sck)
    (!ram_nss && command != '0) |-> (cop_nss == dev_logic))
    else begin
      failures++;
      $error("RAM selected while the coprocessor addresses another device");
    end

endmodule

bind ram_bus_arbiter cpld_glue_props u_props (
  .cop_sck     (cop_sck),
  .command     (command),
  .mcu_ram_req (mcu_ram_req),
  .cop_ram_req (cop_ram_req),
  .cop_nss     (cop_nss),
  .ram_nss     (ram_nss),
  .ram_sck     (ram_sck),
  .ram_mosi    (ram_mosi)
);

//--- tb/cpld_glue_tb.sv
// Reads tb/cpld_stimulus.txt from the project root; SPI half period is eight cop_sck cycles.
`timescale 1ns/1ps

module cpld_glue_tb import cpld_pkg::*; ();

  logic             cop_sck;
  logic             cop_rst_n;
  logic             mcu_nss;
  logic             mcu_sck;
  logic             mcu_mosi;
  logic             mcu_miso;
  logic [dev_w-1:0] cop_nss;
  logic             cop_spi_sck;
  logic             cop_mosi;
  logic             cop_miso;
  logic             cop_nreset;
  logic             ram_nss;
  logic             ram_sck;
  logic             ram_mosi;
  logic             ram_miso;
  logic             usb_nss;
  logic             sdc_nss;
  logic             fpga_nss;
  logic             sys_miso;
  logic             flash_nss;
  logic             flash_sck;
  logic             flash_mosi;
  logic             flash_miso;
  logic             fpga_nce;
  logic             fpga_nconfig;

  // Error counters.
  int mismatches;
  int timeouts;
  int other_errors;

  // Random source and reference state.
  logic [31:0] lfsr;
  logic [7:0]  cmd_model;
  logic [7:0]  last_random;

  cpld_glue_top dut (.*);

  initial begin
    cop_sck = 1'b0;
    forever #2 cop_sck = ~cop_sck;
  end

  // Fibonacci LFSR, taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken.
  task automatic random_byte(output logic [7:0] value);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      value[i] = lfsr[0];
    end
  endtask

  task automatic check_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic half_period();
    repeat (8) @(negedge cop_sck);
  endtask

  // RAM model, it presents one reply bit per SPI bit.
  task automatic ram_drive_bit(input logic [7:0] ram_byte, input int i);
    ram_miso = ram_byte[i];
  endtask

  // Routed RAM pins follow the master; an idle RAM bus sits deselected and low.
  task automatic check_ram_pins(input logic routed, input logic sck_level, input logic mosi_bit);
    check_equal("ram_nss", ram_nss, routed ? 1'b0 : 1'b1);
    check_equal("ram_sck", ram_sck, routed ? sck_level : 1'b0);
    check_equal("ram_mosi", ram_mosi, routed ? mosi_bit : 1'b0);
  endtask

  // Mode 0, LSB first; MISO is taken just before each rising SCK.
  task automatic spi_byte(input logic bus_cop, input logic [7:0] tx, input logic body,
                          input logic routed, input logic [7:0] ram_byte,
                          output logic [7:0] rx);
    for (int i = 0; i < 8; i++) begin
      if (bus_cop) cop_mosi = tx[i];
      else mcu_mosi = tx[i];
      ram_drive_bit(ram_byte, i);
      half_period();
      rx[i] = bus_cop ? cop_miso : mcu_miso;
      check_ram_pins(routed && body, 1'b0, tx[i]);
      if (bus_cop) cop_spi_sck = 1'b1;
      else mcu_sck = 1'b1;
      half_period();
      // The request may rise late in the opcode byte, so only body bits are checked high.
      if (body) check_ram_pins(routed, 1'b1, tx[i]);
      if (bus_cop) cop_spi_sck = 1'b0;
      else mcu_sck = 1'b0;
    end
  endtask

  task automatic wait_nreset_level(input logic level);
    int n;
    n = 0;
    while (cop_nreset !== level && n < 64) begin
      @(negedge cop_sck);
      n++;
    end
    if (cop_nreset !== level) begin
      timeouts++;
      $display("Timeout: cop_nreset did not go %s", level ? "high" : "low");
    end
  endtask

  // Opcode byte then one data byte; readback is MISO during the data byte.
  task automatic run_frame(input logic bus_cop, input logic [dev_w-1:0] dev,
                           input logic [7:0] opcode, input logic [7:0] data,
                           output logic [7:0] readback);
    logic       routed;
    logic       owner_mcu;
    logic       reset_frame;
    logic [7:0] opcode_echo;
    owner_mcu = (cmd_model == 8'h00);
    reset_frame = !bus_cop && (opcode == mcu_op_reset_cop);
    if (bus_cop) routed = (opcode == cop_op_access_ram) && !owner_mcu && (dev == dev_logic);
    else routed = (opcode == mcu_op_access_ram) && owner_mcu;
    if (bus_cop) cop_nss = dev;
    else mcu_nss = 1'b0;
    half_period();
    spi_byte(bus_cop, opcode, 1'b0, routed, 8'h00, opcode_echo);
    if (reset_frame) wait_nreset_level(1'b0);
    spi_byte(bus_cop, data, 1'b1, routed, ~data, readback);
    // Reset request holds for the whole frame.
    if (reset_frame) check_equal("cop_nreset", cop_nreset, 1'b0);
    half_period();
    if (bus_cop) cop_nss = dev_none;
    else mcu_nss = 1'b1;
    if (reset_frame) wait_nreset_level(1'b1);
    // Room for the deselect to pass the synchronizer.
    half_period();
    half_period();
    if (!bus_cop && opcode == mcu_op_write_command) cmd_model = data;
  endtask

  // Select decode with coprocessor clock and data held high.
  // Data bit 0 feeds sys_miso, bit 1 flash_miso.
  task automatic probe_select(input logic [dev_w-1:0] dev, input logic [7:0] data,
                              output logic [7:0] miso);
    cop_nss = dev;
    cop_spi_sck = 1'b1;
    cop_mosi = 1'b1;
    sys_miso = data[0];
    flash_miso = data[1];
    repeat (2) @(negedge cop_sck);
    check_equal("usb_nss", usb_nss, dev != dev_usb);
    check_equal("sdc_nss", sdc_nss, dev != dev_sdcard);
    check_equal("fpga_nss", fpga_nss, dev != dev_fpga);
    check_equal("flash_nss", flash_nss, dev != dev_flash);
    check_equal("fpga_nce", fpga_nce, dev == dev_flash);
    check_equal("fpga_nconfig", fpga_nconfig, dev != dev_flash);
    // Flash clock and data pass only while the flash is selected.
    check_equal("flash_sck", flash_sck, dev == dev_flash);
    check_equal("flash_mosi", flash_mosi, dev == dev_flash);
    check_equal("ram_nss", ram_nss, 1'b1);
    miso = {7'd0, cop_miso};
    cop_nss = dev_none;
    cop_spi_sck = 1'b0;
    cop_mosi = 1'b0;
    sys_miso = 1'b0;
    flash_miso = 1'b0;
    repeat (8) @(negedge cop_sck);
  endtask

  initial begin
    int               fd;
    int               code;
    int               assert_failures;
    logic [31:0]      bus;
    logic [31:0]      dev;
    logic [31:0]      opcode;
    logic [31:0]      data;
    logic [31:0]      exp_field;
    logic [7:0]       tx;
    logic [7:0]       readback;
    reg [8*96-1:0]    line_buf;
    cop_rst_n = 1'b0;
    mcu_nss = 1'b1;
    mcu_sck = 1'b0;
    mcu_mosi = 1'b0;
    cop_nss = dev_none;
    cop_spi_sck = 1'b0;
    cop_mosi = 1'b0;
    ram_miso = 1'b0;
    sys_miso = 1'b0;
    flash_miso = 1'b0;
    mismatches = 0;
    timeouts = 0;
    other_errors = 0;
    lfsr = 32'h638d_5041;
    cmd_model = 8'h00;
    last_random = 8'h00;
    repeat (8) @(negedge cop_sck);
    cop_rst_n = 1'b1;
    repeat (4) @(negedge cop_sck);
    // Everything inactive after reset.
    check_equal("usb_nss", usb_nss, 1'b1);
    check_equal("sdc_nss", sdc_nss, 1'b1);
    check_equal("fpga_nss", fpga_nss, 1'b1);
    check_equal("flash_nss", flash_nss, 1'b1);
    check_equal("ram_nss", ram_nss, 1'b1);
    check_equal("cop_nreset", cop_nreset, 1'b1);
    fd = $fopen("tb/cpld_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the stimulus file tb/cpld_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        code = $fgets(line_buf, fd);
        // Comment lines fail the hex scan and are skipped.
        if (code > 0 &&
            $sscanf(line_buf, "%h %h %h %h %h", bus, dev, opcode, data, exp_field) == 5) begin
          if (data == 32'h100) begin
            random_byte(tx);
            last_random = tx;
          end else begin
            tx = data[7:0];
          end
          if (bus == 2) probe_select(dev[dev_w-1:0], tx, readback);
          else run_frame(bus[0], dev[dev_w-1:0], opcode[7:0], tx, readback);
          if (exp_field == 32'h100) begin
            check_equal(bus == 0 ? "mcu_miso" : "cop_miso", readback, last_random);
          end else if (exp_field != 32'h200) begin
            check_equal(bus == 0 ? "mcu_miso" : "cop_miso", readback, exp_field[7:0]);
          end
        end
      end
      $fclose(fd);
    end
    assert_failures = dut.u_arbiter.u_props.failures;
    $display("Errors: %0d mismatches, %0d timeouts, %0d other, %0d assertion failures",
             mismatches, timeouts, other_errors, assert_failures);
    if (mismatches + timeouts + other_errors + assert_failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb/cpld_stimulus.txt
# bus (0 mcu, 1 cop, 2 select probe), dev, opcode, data, expected readback; all hex
# data 100 draws a random byte, expected 100 is that byte, 200 is unchecked; RAM replies ~data
0 0 01 00 00
1 1 01 00 00
0 0 03 5a a5
1 1 03 3c 200
0 0 02 100 200
1 1 01 00 100
1 1 02 100 200
0 0 01 00 100
0 0 02 81 200
1 1 01 00 81
1 1 03 c3 3c
0 0 03 77 200
0 0 04 00 200
1 1 02 e7 200
0 0 01 00 e7
2 0 00 03 00
2 1 00 03 200
2 2 00 01 01
2 3 00 02 00
2 4 00 01 01
2 5 00 02 01
2 5 00 01 00
2 6 00 03 00
0 0 02 00 200
0 0 03 0f f0

//--- vlog.f
src/cpld_pkg.sv
src/spi_byte_engine.sv
src/mcu_port_ctrl.sv
src/cop_port_ctrl.sv
src/ram_bus_arbiter.sv
src/cpld_glue_top.sv
tb/cpld_glue_props.sv
tb/cpld_glue_tb.sv
